// File: computer.f
isa_pkg.sv
machine_pkg.sv
main_memory.sv
alu.sv
control_unit.sv
out_port.sv
computer.sv
computer_asserts.sv
computer_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= computer_tb
RTL_TOP   ?= computer
FILELIST  ?= computer.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+1000

SOURCES := $(shell cat $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(RUN_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@! grep -q "STATUS: FAIL" $(LOG)
	@grep -q "STATUS: PASS" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: computer_tb.sv
`timescale 1ns/1ps

module computer_tb;

    localparam int OUT_DEPTH   = 4;
    localparam int OUT_CREDITS = 2;
    localparam int DATA_BASE   = 512;  // Operands sit in the upper half
    localparam int WAIT_LIMIT  = 5000;
    localparam logic [15:0] EDGES [4] = '{16'h0000, 16'hffff, 16'h8001, 16'h7ffe};

    logic                  clock;
    logic                  arst_n;
    logic                  start;
    logic                  load_valid;
    machine_pkg::mem_req_t load_req;
    logic                  out_credit;
    logic                  out_valid;
    machine_pkg::word_t    out_data;
    logic                  halted;

    logic [15:0] prog [$];
    logic [15:0] data [$];
    logic [15:0] expect_q [$];
    logic [15:0] got [$];
    int          errors;
    int          owed;       // Words received but not yet credited back
    logic        credit_on;

    computer #(
        .OUT_DEPTH   (OUT_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) u_dut (
        .clock, .arst_n, .start, .load_valid, .load_req,
        .out_credit, .out_valid, .out_data, .halted
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    function automatic logic [15:0] encode(int cls, int fn, int addr);
        return {cls[1:0], fn[3:0], addr[9:0]};
    endfunction

    // Expected ALU results straight from the ISA table
    function automatic logic [15:0] model_alu(int op, logic [15:0] a, logic [15:0] b);
        case (op)
            0:  return a + b;
            1:  return a - b;
            2:  return a * b;
            3:  return (b == 16'd0) ? 16'hffff : a / b;
            4:  return {a[14:0], 1'b0};
            5:  return {1'b0, a[15:1]};
            6:  return {a[14:0], a[15]};
            7:  return {a[0], a[15:1]};
            8:  return a & b;
            9:  return a | b;
            10: return a ^ b;
            11: return ~(a | b);
            12: return ~(a & b);
            13: return ~(a ^ b);
            14: return (a > b) ? 16'd1 : 16'd0;
            default: return (a == b) ? 16'd1 : 16'd0;
        endcase
    endfunction

    function automatic int put_data(logic [15:0] value);
        data.push_back(value);
        return DATA_BASE + data.size() - 1;
    endfunction

    task automatic emit(int cls, int fn, int addr);
        prog.push_back(encode(cls, fn, addr));
    endtask

    task automatic new_program();
        prog.delete();
        data.delete();
        expect_q.delete();
        got.delete();
    endtask

    task automatic add_alu_case(int op, logic [15:0] a, logic [15:0] b);
        int pa;
        int pb;
        pa = put_data(a);
        pb = put_data(b);
        emit(isa_pkg::CLS_MEM, isa_pkg::FN_LOAD, pa);
        emit(isa_pkg::CLS_ALU, op, pb);
        emit(isa_pkg::CLS_IO, isa_pkg::FN_OUT, 0);
        expect_q.push_back(model_alu(op, a, b));
    endtask

    // One clock with output capture and credit return
    task automatic step_clock();
        @(posedge clock);
        if (out_valid) begin
            got.push_back(out_data);
            owed++;
        end
        if (!arst_n) begin
            owed = 0;
        end
        if (credit_on && owed > 0) begin
            out_credit <= 1'b1;
            owed--;
        end else begin
            out_credit <= 1'b0;
        end
    endtask

    task automatic apply_reset();
        arst_n <= 1'b0;
        repeat (5) step_clock();
        arst_n <= 1'b1;
        step_clock();
        assert (!out_valid) else begin
            errors++;
            $display("ERR %0t out_valid expected 0 actual %b after reset", $time, out_valid);
        end
        assert (!halted) else begin
            errors++;
            $display("ERR %0t halted expected 0 actual %b after reset", $time, halted);
        end
    endtask

    task automatic write_word(int addr, logic [15:0] w);
        machine_pkg::mem_req_t req;
        req.write  = 1'b1;
        req.addr   = addr[9:0];
        req.wdata  = w;
        load_valid <= 1'b1;
        load_req   <= req;
        step_clock();
    endtask

    task automatic load_program();
        foreach (prog[i]) write_word(i, prog[i]);
        foreach (data[i]) write_word(DATA_BASE + i, data[i]);
        load_valid <= 1'b0;
    endtask

    task automatic pulse_start();
        start <= 1'b1;
        step_clock();
        start <= 1'b0;
        step_clock();  // Old halted level is gone after this
    endtask

    task automatic wait_halted();
        int cycles;
        cycles = 0;
        while (!halted && cycles < WAIT_LIMIT) begin
            step_clock();
            cycles++;
        end
        if (!halted) begin
            errors++;
            $display("Timeout: the DUT did not halt within %0d cycles", WAIT_LIMIT);
        end
    endtask

    task automatic wait_words(int n);
        int cycles;
        cycles = 0;
        while (got.size() < n && cycles < WAIT_LIMIT) begin
            step_clock();
            cycles++;
        end
        if (got.size() < n) begin
            errors++;
            $display("Timeout: only %0d of %0d output words arrived", got.size(), n);
        end
    endtask

    task automatic check_word(int idx, logic [15:0] exp, logic [15:0] act);
        assert (act === exp) else begin
            errors++;
            $display("ERR %0t out_data[%0d] expected %h actual %h", $time, idx, exp, act);
        end
    endtask

    task automatic collect_and_compare();
        wait_halted();
        wait_words(expect_q.size());
        repeat (4 * OUT_DEPTH) step_clock();  // Catch any surplus word
        assert (got.size() == expect_q.size()) else begin
            errors++;
            $display("ERR %0t out_data word count expected %0d actual %0d",
                     $time, expect_q.size(), got.size());
        end
        foreach (expect_q[i]) begin
            if (i < got.size()) begin
                check_word(i, expect_q[i], got[i]);
            end
        end
    endtask

    task automatic run_and_collect();
        pulse_start();
        collect_and_compare();
    endtask

    task automatic test_arithmetic();
        new_program();
        for (int op = 0; op < 4; op++) begin
            add_alu_case(op, 16'($urandom), 16'($urandom));
        end
        add_alu_case(3, 16'($urandom), 16'h0000);  // Divide by zero
        add_alu_case(3, 16'($urandom), 16'($urandom_range(1, 255)));
        emit(isa_pkg::CLS_FLOW, isa_pkg::FN_HALT, 0);
        load_program();
        run_and_collect();
    endtask

    task automatic test_logic();
        logic [15:0] x;
        new_program();
        for (int op = 4; op < 16; op++) begin
            add_alu_case(op, 16'($urandom), 16'($urandom));
            add_alu_case(op, EDGES[op % 4], EDGES[(op + 1) % 4]);
        end
        x = 16'($urandom);
        add_alu_case(14, x, x);
        add_alu_case(15, x, x);
        emit(isa_pkg::CLS_FLOW, isa_pkg::FN_HALT, 0);
        load_program();
        run_and_collect();
    endtask

    task automatic test_flow();
        logic [15:0] value;
        int          slot;
        int          one_addr;
        int          loop_pc;
        value = 16'($urandom);
        new_program();
        slot     = put_data(~value);  // Overwritten by the store
        one_addr = put_data(16'd1);
        emit(isa_pkg::CLS_MEM, isa_pkg::FN_LOAD, put_data(value));
        emit(isa_pkg::CLS_MEM, isa_pkg::FN_STORE, slot);
        emit(isa_pkg::CLS_MEM, isa_pkg::FN_LOAD, put_data(16'h0000));
        emit(isa_pkg::CLS_MEM, isa_pkg::FN_LOAD, slot);
        emit(isa_pkg::CLS_IO, isa_pkg::FN_OUT, 0);
        expect_q.push_back(value);
        emit(isa_pkg::CLS_FLOW, isa_pkg::FN_JUMP, prog.size() + 2);  // Skips the next OUT
        emit(isa_pkg::CLS_IO, isa_pkg::FN_OUT, 0);
        emit(isa_pkg::CLS_MEM, isa_pkg::FN_LOAD, put_data(16'd3));
        loop_pc = prog.size();
        emit(isa_pkg::CLS_IO, isa_pkg::FN_OUT, 0);
        emit(isa_pkg::CLS_ALU, isa_pkg::OP_SUB, one_addr);
        emit(isa_pkg::CLS_FLOW, isa_pkg::FN_JZ, loop_pc + 4);
        emit(isa_pkg::CLS_FLOW, isa_pkg::FN_JUMP, loop_pc);
        emit(isa_pkg::CLS_FLOW, isa_pkg::FN_HALT, 0);
        for (int n = 3; n > 0; n--) begin
            expect_q.push_back(16'(n));
        end
        load_program();
        run_and_collect();
    endtask

    task automatic test_backpressure();
        logic [15:0] value;
        credit_on = 1'b0;
        apply_reset();
        new_program();
        for (int i = 0; i < OUT_CREDITS + OUT_DEPTH + 2; i++) begin
            value = 16'($urandom);
            emit(isa_pkg::CLS_MEM, isa_pkg::FN_LOAD, put_data(value));
            emit(isa_pkg::CLS_IO, isa_pkg::FN_OUT, 0);
            expect_q.push_back(value);
        end
        emit(isa_pkg::CLS_FLOW, isa_pkg::FN_HALT, 0);
        load_program();
        pulse_start();
        for (int n = 0; n < 200; n++) begin
            step_clock();
            assert (!halted) else begin
                errors++;
                $display("ERR %0t halted expected 0 actual %b while waiting at an OUT",
                         $time, halted);
            end
        end
        assert (got.size() == OUT_CREDITS) else begin
            errors++;
            $display("ERR %0t out_valid words expected %0d actual %0d",
                     $time, OUT_CREDITS, got.size());
        end
        credit_on = 1'b1;
        collect_and_compare();
    endtask

    task automatic test_restart();
        logic [15:0] a;
        logic [15:0] b;
        assert (halted) else begin
            errors++;
            $display("ERR %0t halted expected 1 actual %b after HALT", $time, halted);
        end
        a = 16'($urandom);
        b = 16'($urandom);
        new_program();
        add_alu_case(isa_pkg::OP_XOR, a, b);
        add_alu_case(isa_pkg::OP_ADD, a, b);
        emit(isa_pkg::CLS_FLOW, isa_pkg::FN_HALT, 0);
        load_program();
        run_and_collect();
    endtask

    initial begin
        void'($urandom(32'h1b35ab73));
        errors     = 0;
        owed       = 0;
        credit_on  = 1'b1;
        arst_n     = 1'b0;
        start      = 1'b0;
        load_valid = 1'b0;
        load_req   = '0;
        out_credit = 1'b0;
        apply_reset();
        test_arithmetic();
        test_logic();
        test_flow();
        test_backpressure();
        test_restart();
        $display("Check errors: %0d, assertion failures: %0d",
                 errors, u_dut.u_out.u_asserts.fail_count);
        if (errors == 0 && u_dut.u_out.u_asserts.fail_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: computer_asserts.sv
`timescale 1ns/1ps

module computer_asserts #(
    parameter int OUT_CREDITS = 2,
    parameter int CRD_W       = 2
) (
    input logic             clock,
    input logic             arst_n,
    input logic             out_push,
    input logic             out_space,
    input logic             out_valid,
    input logic [CRD_W-1:0] credits
);

    int fail_count = 0;

    // A word only leaves while a credit is held
    valid_needs_credit: assert property (@(posedge clock) disable iff (!arst_n)
        out_valid |-> $past(credits) != '0)
        else begin
            fail_count++;
            $error("out_valid was raised with no credit held");
        end

    credit_bound: assert property (@(posedge clock) disable iff (!arst_n)
        int'(credits) <= OUT_CREDITS)
        else begin
            fail_count++;
            $error("Credit count is above its reset value");
        end

    push_needs_space: assert property (@(posedge clock) disable iff (!arst_n)
        out_push |-> out_space)
        else begin
            fail_count++;
            $error("out_push while the output queue is full");
        end

endmodule

bind out_port computer_asserts #(
    .OUT_CREDITS (OUT_CREDITS),
    .CRD_W       (CRD_W)
) u_asserts (
    .clock, .arst_n, .out_push, .out_space, .out_valid, .credits
);

// File: computer.sv
`timescale 1ns/1ps

module computer #(
    parameter int OUT_DEPTH   = 4,
    parameter int OUT_CREDITS = 2
) (
    input  logic                  clock,
    input  logic                  arst_n,
    input  logic                  start,
    input  logic                  load_valid,
    input  machine_pkg::mem_req_t load_req,
    input  logic                  out_credit,
    output logic                  out_valid,
    output machine_pkg::word_t    out_data,
    output logic                  halted
);

    logic                  mem_valid;
    machine_pkg::mem_req_t mem_req;
    machine_pkg::word_t    mem_rdata;
    isa_pkg::alu_op_t      alu_op;
    machine_pkg::word_t    alu_a;
    machine_pkg::word_t    alu_b;
    machine_pkg::word_t    alu_result;
    logic                  out_space;
    logic                  out_push;
    machine_pkg::word_t    out_word;

    main_memory u_mem (
        .clock, .arst_n, .load_valid, .load_req, .mem_valid, .mem_req, .mem_rdata
    );

    control_unit u_ctrl (
        .clock, .arst_n, .start, .mem_valid, .mem_req, .mem_rdata,
        .alu_op, .alu_a, .alu_b, .alu_result,
        .out_space, .out_push, .out_word, .halted
    );

    alu u_alu (
        .alu_op, .alu_a, .alu_b, .alu_result
    );

    out_port #(
        .OUT_DEPTH   (OUT_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) u_out (
        .clock, .arst_n, .out_push, .out_word, .out_space,
        .out_valid, .out_data, .out_credit
    );

endmodule

// File: out_port.sv
`timescale 1ns/1ps

module out_port #(
    parameter int OUT_DEPTH   = 4,
    parameter int OUT_CREDITS = 2
) (
    input  logic               clock,
    input  logic               arst_n,
    input  logic               out_push,
    input  machine_pkg::word_t out_word,
    output logic               out_space,
    output logic               out_valid,
    output machine_pkg::word_t out_data,
    input  logic               out_credit
);

    localparam int PTR_W = (OUT_DEPTH > 1) ? $clog2(OUT_DEPTH) : 1;
    localparam int CNT_W = $clog2(OUT_DEPTH + 1);
    localparam int CRD_W = $clog2(OUT_CREDITS + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] cnt_t;
    typedef logic [CRD_W-1:0] crd_t;

    machine_pkg::word_t fifo [OUT_DEPTH];
    ptr_t wr_ptr;
    ptr_t rd_ptr;
    cnt_t count;
    crd_t credits;
    logic send;

    function automatic ptr_t next_ptr(ptr_t ptr);
        return (ptr == ptr_t'(OUT_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign out_space = (count != cnt_t'(OUT_DEPTH));
    assign send      = (count != '0) && (credits != '0);  // Head word leaves on a credit

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            credits   <= crd_t'(OUT_CREDITS);
            out_valid <= 1'b0;
        end else begin
            out_valid <= send;
            if (out_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (send) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (out_push && !send) begin
                count <= count + 1'b1;
            end else if (send && !out_push) begin
                count <= count - 1'b1;
            end
            // Spend and return in one cycle cancel out
            if (send && !out_credit) begin
                credits <= credits - 1'b1;
            end else if (!send && out_credit && credits != crd_t'(OUT_CREDITS)) begin
                credits <= credits + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (out_push) begin
            fifo[wr_ptr] <= out_word;
        end
        if (send) begin
            out_data <= fifo[rd_ptr];
        end
    end

endmodule

// File: control_unit.sv
`timescale 1ns/1ps

module control_unit (
    input  logic                  clock,
    input  logic                  arst_n,
    input  logic                  start,
    output logic                  mem_valid,
    output machine_pkg::mem_req_t mem_req,
    input  machine_pkg::word_t    mem_rdata,
    output isa_pkg::alu_op_t      alu_op,
    output machine_pkg::word_t    alu_a,
    output machine_pkg::word_t    alu_b,
    input  machine_pkg::word_t    alu_result,
    input  logic                  out_space,
    output logic                  out_push,
    output machine_pkg::word_t    out_word,
    output logic                  halted
);

    typedef enum logic [2:0] {IDLE, FETCH, WAIT, DECODE, EXECUTE, HALTED} state_t;

    state_t             state;
    machine_pkg::addr_t pc;
    isa_pkg::instr_t    ir;
    machine_pkg::word_t mbr;
    machine_pkg::word_t acc;

    isa_pkg::instr_class_t fetch_cls;
    isa_pkg::instr_class_t ir_cls;
    isa_pkg::func_t        ir_func;
    machine_pkg::addr_t    fetch_addr;
    machine_pkg::addr_t    ir_addr;
    logic                  fetch_needs_op;

    // Decode straight off the read data during WAIT
    assign fetch_cls  = isa_pkg::instr_class(mem_rdata);
    assign fetch_addr = mem_rdata[machine_pkg::ADDR_W-1:0];
    assign fetch_needs_op = (fetch_cls == isa_pkg::CLS_ALU) ||
                            (fetch_cls == isa_pkg::CLS_MEM &&
                             isa_pkg::instr_func(mem_rdata) == isa_pkg::FN_LOAD);

    assign ir_cls  = isa_pkg::instr_class(ir);
    assign ir_func = isa_pkg::instr_func(ir);
    assign ir_addr = ir[machine_pkg::ADDR_W-1:0];

    assign alu_op   = isa_pkg::alu_op_t'(ir_func);
    assign alu_a    = acc;
    assign alu_b    = mbr;
    assign out_word = acc;
    assign halted   = (state == HALTED);

    always_comb begin
        mem_valid = 1'b0;
        mem_req   = '0;
        out_push  = 1'b0;
        case (state)
            FETCH: begin
                mem_valid    = 1'b1;
                mem_req.addr = pc;
            end
            WAIT: begin
                mem_valid    = fetch_needs_op;  // Operand read for ALU and load
                mem_req.addr = fetch_addr;
            end
            EXECUTE: begin
                if (ir_cls == isa_pkg::CLS_MEM && ir_func == isa_pkg::FN_STORE) begin
                    mem_valid     = 1'b1;
                    mem_req.write = 1'b1;
                    mem_req.addr  = ir_addr;
                    mem_req.wdata = acc;
                end
                if (ir_cls == isa_pkg::CLS_IO && ir_func == isa_pkg::FN_OUT) begin
                    out_push = out_space;
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
            pc    <= '0;
            acc   <= '0;
        end else begin
            case (state)
                IDLE, HALTED: begin
                    if (start) begin
                        pc    <= '0;
                        state <= FETCH;
                    end
                end
                FETCH:  state <= WAIT;
                WAIT: begin
                    pc    <= pc + 1'b1;  // Wraps at 1024
                    state <= fetch_needs_op ? DECODE : EXECUTE;
                end
                DECODE: state <= EXECUTE;
                EXECUTE: begin
                    state <= FETCH;
                    case (ir_cls)
                        isa_pkg::CLS_ALU: acc <= alu_result;
                        isa_pkg::CLS_MEM: begin
                            if (ir_func == isa_pkg::FN_LOAD) begin
                                acc <= mbr;
                            end
                        end
                        isa_pkg::CLS_FLOW: begin
                            if (ir_func == isa_pkg::FN_JUMP ||
                                (ir_func == isa_pkg::FN_JZ && acc == '0)) begin
                                pc <= ir_addr;
                            end
                            if (ir_func == isa_pkg::FN_HALT) begin
                                state <= HALTED;
                            end
                        end
                        isa_pkg::CLS_IO: begin
                            if (ir_func == isa_pkg::FN_OUT && !out_space) begin
                                state <= EXECUTE;  // Stall until queue has room
                            end
                        end
                    endcase
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Instruction and operand latches
    always_ff @(posedge clock) begin
        if (state == WAIT) begin
            ir <= mem_rdata;
        end
        if (state == DECODE) begin
            mbr <= mem_rdata;
        end
    end

endmodule

// File: alu.sv
`timescale 1ns/1ps

module alu (
    input  isa_pkg::alu_op_t   alu_op,
    input  machine_pkg::word_t alu_a,
    input  machine_pkg::word_t alu_b,
    output machine_pkg::word_t alu_result
);

    localparam int MSB = machine_pkg::WORD_W - 1;

    always_comb begin
        unique case (alu_op)
            isa_pkg::OP_ADD:  alu_result = alu_a + alu_b;
            isa_pkg::OP_SUB:  alu_result = alu_a - alu_b;
            isa_pkg::OP_MUL:  alu_result = alu_a * alu_b;  // Low half of product
            isa_pkg::OP_DIV: begin
                if (alu_b == '0) begin
                    alu_result = '1;  // Divide by zero
                end else begin
                    alu_result = alu_a / alu_b;
                end
            end
            isa_pkg::OP_SHL:  alu_result = alu_a << 1;
            isa_pkg::OP_SHR:  alu_result = alu_a >> 1;
            isa_pkg::OP_ROL:  alu_result = {alu_a[MSB-1:0], alu_a[MSB]};
            isa_pkg::OP_ROR:  alu_result = {alu_a[0], alu_a[MSB:1]};
            isa_pkg::OP_AND:  alu_result = alu_a & alu_b;
            isa_pkg::OP_OR:   alu_result = alu_a | alu_b;
            isa_pkg::OP_XOR:  alu_result = alu_a ^ alu_b;
            isa_pkg::OP_NOR:  alu_result = ~(alu_a | alu_b);
            isa_pkg::OP_NAND: alu_result = ~(alu_a & alu_b);
            isa_pkg::OP_XNOR: alu_result = ~(alu_a ^ alu_b);
            isa_pkg::OP_GT:   alu_result = machine_pkg::word_t'(alu_a > alu_b);  // Unsigned
            isa_pkg::OP_EQ:   alu_result = machine_pkg::word_t'(alu_a == alu_b);
        endcase
    end

endmodule

// File: main_memory.sv
`timescale 1ns/1ps

module main_memory (
    input  logic                  clock,
    input  logic                  arst_n,
    input  logic                  load_valid,
    input  machine_pkg::mem_req_t load_req,
    input  logic                  mem_valid,
    input  machine_pkg::mem_req_t mem_req,
    output machine_pkg::word_t    mem_rdata
);

    machine_pkg::word_t mem [machine_pkg::MEM_WORDS];

    logic ctrl_write;
    logic ctrl_read;
    logic load_write;

    assign ctrl_write = mem_valid && mem_req.write;
    assign ctrl_read  = mem_valid && !mem_req.write;
    assign load_write = load_valid && load_req.write && !mem_valid;  // Control port wins

    always_ff @(posedge clock) begin
        if (ctrl_write) begin
            mem[mem_req.addr] <= mem_req.wdata;
        end else if (load_write) begin
            mem[load_req.addr] <= load_req.wdata;
        end
    end

    // Registered read with data valid the cycle after the request
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            mem_rdata <= '0;
        end else if (ctrl_read) begin
            mem_rdata <= mem[mem_req.addr];
        end
    end

endmodule

// File: machine_pkg.sv
package machine_pkg;

    localparam int WORD_W    = 16;
    localparam int ADDR_W    = 10;
    localparam int MEM_WORDS = 1 << ADDR_W;  // 1024 words

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [ADDR_W-1:0] addr_t;

    // One memory access that reads when write is low
    typedef struct packed {
        logic  write;
        addr_t addr;
        word_t wdata;
    } mem_req_t;

endpackage

// File: isa_pkg.sv
package isa_pkg;

    localparam int INSTR_W  = 16;
    localparam int CLS_LSB  = 14;  // Class in bits 15:14
    localparam int FUNC_LSB = 10;  // Function in bits 13:10

    typedef logic [INSTR_W-1:0] instr_t;
    typedef logic [3:0]         func_t;

    typedef enum logic [1:0] {
        CLS_ALU,   // acc = acc op mem
        CLS_MEM,   // Load or store
        CLS_FLOW,  // Jump, jz, halt
        CLS_IO     // Out
    } instr_class_t;

    typedef enum logic [3:0] {
        OP_ADD = 4'd0, OP_SUB, OP_MUL, OP_DIV,
        OP_SHL, OP_SHR, OP_ROL, OP_ROR,
        OP_AND, OP_OR, OP_XOR, OP_NOR,
        OP_NAND, OP_XNOR, OP_GT, OP_EQ
    } alu_op_t;

    localparam func_t FN_LOAD  = 4'd0;
    localparam func_t FN_STORE = 4'd1;
    localparam func_t FN_JUMP  = 4'd0;
    localparam func_t FN_JZ    = 4'd1;
    localparam func_t FN_HALT  = 4'd2;
    localparam func_t FN_OUT   = 4'd0;

    function automatic instr_class_t instr_class(instr_t instr);
        return instr_class_t'(instr[CLS_LSB +: $bits(instr_class_t)]);
    endfunction

    function automatic func_t instr_func(instr_t instr);
        return instr[FUNC_LSB +: $bits(func_t)];
    endfunction

endpackage
